// ==== tb.f ====
hdl/uart_pkg.sv
hdl/bit_timer.sv
hdl/rx_line_filter.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_core.sv
dv/uart_tb.sv

// ==== Makefile ====
# Verilator build and run for the UART subsystem

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= uart_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := TEST FAILED

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
	  echo "simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/uart_tb.sv ====
module uart_tb
  import uart_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          FRAME_CYCLES = (DATA_BITS + 2) * BIT_PERIOD;
  localparam int          RX_TIMEOUT   = 3 * FRAME_CYCLES;
  localparam int          NUM_LOOP     = 8;
  localparam logic [31:0] LFSR_SEED    = 32'd99779;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

  logic       rst; // clock
  logic       clk; // reset
  logic       rx;
  logic       tx;
  uart_data_t tx_data;
  logic       wr;
  logic       tx_ready;
  uart_data_t rx_data;
  logic       rx_full;
  logic       rd;

  logic        rx_drive;
  logic        loopback;
  logic [31:0] lfsr_state;
  uart_data_t  sent [NUM_LOOP];
  int          checks;
  int          errors;

  assign rx = loopback ? tx : rx_drive; // line source select

  uart_core u_uart_core (
    .rst      (rst),
    .clk      (clk),
    .rx       (rx),
    .tx       (tx),
    .tx_data  (tx_data),
    .wr       (wr),
    .tx_ready (tx_ready),
    .rx_data  (rx_data),
    .rx_full  (rx_full),
    .rd       (rd)
  );

  always #5 rst = ~rst;

  task automatic next_cycle();
    @(posedge rst);
    #1;
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  task automatic random_byte(output uart_data_t b);
    for (int i = 0; i < DATA_BITS; i++) begin
      b[i] = lfsr_state[0]; // one step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic compare_data(input string name, input uart_data_t got,
                              input uart_data_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Error at %0t ns: %s got 0x%h, expected 0x%h", $time, name, got, expected);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Error at %0t ns: %s got %b, expected %b", $time, name, got, expected);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("%-18s ok", name);
    end else begin
      $display("%-18s %0d error(s)", name, errors - errs_before);
    end
  endtask

  task automatic wait_rx_full(input string what, output bit seen);
    int cnt;
    cnt = 0;
    while (!rx_full && cnt < RX_TIMEOUT) begin
      next_cycle();
      cnt++;
    end
    seen = rx_full;
    if (!seen) begin
      errors++;
      $display("timeout: rx_full never rose during %s", what);
    end
  endtask

  // start bit, data lsb first, stop bit
  task automatic drive_frame(input uart_data_t b);
    rx_drive = 1'b0;
    repeat (BIT_PERIOD) next_cycle();
    for (int i = 0; i < DATA_BITS; i++) begin
      rx_drive = b[i];
      repeat (BIT_PERIOD) next_cycle();
    end
    rx_drive = 1'b1;
    repeat (BIT_PERIOD) next_cycle();
  endtask

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    compare_bit("tx", tx, 1'b1);
    compare_bit("tx_ready", tx_ready, 1'b1);
    compare_bit("rx_full", rx_full, 1'b0);
    compare_data("rx_data", rx_data, '0);
    report_test("reset_state", e0);
  endtask

  task automatic test_transmit_frame(input uart_data_t b);
    int   e0;
    int   elapsed;
    logic expected;
    e0 = errors;
    elapsed = 0;
    tx_data = b;
    wr = 1'b1;
    next_cycle(); // wr edge
    wr = 1'b0;
    for (int k = 0; k < DATA_BITS + 2; k++) begin
      while (elapsed < BIT_PERIOD / 2 + k * BIT_PERIOD) begin
        next_cycle();
        elapsed++;
      end
      if (k == 0) begin
        expected = 1'b0;
      end else if (k == DATA_BITS + 1) begin
        expected = 1'b1;
      end else begin
        expected = b[k-1];
      end
      compare_bit("tx", tx, expected);
      compare_bit("tx_ready", tx_ready, 1'b0);
    end
    while (elapsed < FRAME_CYCLES - 1) begin
      next_cycle();
      elapsed++;
    end
    compare_bit("tx_ready", tx_ready, 1'b0); // last stop cycle
    next_cycle();
    compare_bit("tx_ready", tx_ready, 1'b1);
    report_test("transmit_frame", e0);
  endtask

  task automatic test_receive_frame(input uart_data_t b);
    int e0;
    bit seen;
    e0 = errors;
    drive_frame(b);
    wait_rx_full("receive_frame", seen);
    if (seen) begin
      compare_data("rx_data", rx_data, b);
      rd = 1'b1;
      next_cycle();
      rd = 1'b0;
      compare_bit("rx_full", rx_full, 1'b0);
    end
    report_test("receive_frame", e0);
  endtask

  task automatic test_glitch_rejection();
    int e0;
    e0 = errors;
    rx_drive = 1'b0;
    repeat (FILTER_LEN - 1) next_cycle(); // one sample short of a full window
    rx_drive = 1'b1;
    for (int i = 0; i < 2 * FRAME_CYCLES; i++) begin
      next_cycle();
      if (rx_full) begin
        compare_bit("rx_full", rx_full, 1'b0);
        break;
      end
    end
    report_test("glitch_rejection", e0);
  endtask

  task automatic write_bytes();
    int cnt;
    for (int i = 0; i < NUM_LOOP; i++) begin
      cnt = 0;
      while (!tx_ready && cnt < 2 * FRAME_CYCLES) begin
        next_cycle();
        cnt++;
      end
      if (!tx_ready) begin
        errors++;
        $display("timeout: tx_ready stayed low before byte %0d", i);
        return;
      end
      tx_data = sent[i];
      wr = 1'b1;
      next_cycle();
      wr = 1'b0;
    end
  endtask

  task automatic read_bytes();
    bit seen;
    for (int i = 0; i < NUM_LOOP; i++) begin
      wait_rx_full("loopback", seen);
      if (!seen) begin
        return;
      end
      compare_data("rx_data", rx_data, sent[i]);
      rd = 1'b1;
      next_cycle();
      rd = 1'b0;
    end
  endtask

  task automatic test_loopback();
    int e0;
    e0 = errors;
    for (int i = 0; i < NUM_LOOP; i++) begin
      random_byte(sent[i]);
    end
    loopback = 1'b1;
    fork
      write_bytes();
      read_bytes();
    join
    loopback = 1'b0;
    report_test("loopback", e0);
  endtask

  initial begin
    uart_data_t b;
    rst = 1'b0;
    clk = 1'b1;
    rx_drive = 1'b1;
    loopback = 1'b0;
    tx_data = '0;
    wr = 1'b0;
    rd = 1'b0;
    checks = 0;
    errors = 0;
    lfsr_state = LFSR_SEED;
    repeat (10) @(posedge rst);
    #1;
    clk = 1'b0;
    test_reset_state();
    random_byte(b);
    test_transmit_frame(b);
    random_byte(b);
    test_receive_frame(b);
    test_glitch_rejection();
    test_loopback();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/uart_core.sv ====
module uart_core
  import uart_pkg::*;
(
  input  logic       rst,
  input  logic       clk,
  input  logic       rx,       // serial in
  output logic       tx,       // serial out
  input  uart_data_t tx_data,
  input  logic       wr,       // one-cycle write strobe
  output logic       tx_ready,
  output uart_data_t rx_data,
  output logic       rx_full,  // held until rd
  input  logic       rd        // one-cycle read strobe
);

  logic line_clean;

  // rx stage 1
  rx_line_filter u_rx_line_filter (
    .rst        (rst),
    .clk        (clk),
    .rx         (rx),
    .line_clean (line_clean)
  );

  // rx stage 2
  uart_rx u_uart_rx (
    .rst        (rst),
    .clk        (clk),
    .line_clean (line_clean),
    .rd         (rd),
    .rx_data    (rx_data),
    .rx_full    (rx_full)
  );

  uart_tx u_uart_tx (
    .rst      (rst),
    .clk      (clk),
    .tx_data  (tx_data),
    .wr       (wr),
    .tx       (tx),
    .tx_ready (tx_ready)
  );

endmodule

// ==== hdl/uart_tx.sv ====
module uart_tx
  import uart_pkg::*;
(
  input  logic       rst,
  input  logic       clk,
  input  uart_data_t tx_data,
  input  logic       wr,
  output logic       tx,
  output logic       tx_ready
);

  line_state_t              state;
  line_state_t              state_next;
  logic [BIT_CNT_WIDTH-1:0] bit_cnt;
  uart_data_t               shift;
  uart_data_t               shift_next;
  logic                     tim_enable;
  logic                     tim_last;
  logic                     bits_done;
  logic                     tx_next;

  assign tim_enable = (state != IDLE);
  assign bits_done  = (bit_cnt == BIT_CNT_WIDTH'(DATA_BITS - 1));
  assign tx_ready   = (state == IDLE) && !wr;

  bit_timer u_bit_timer (
    .rst    (rst),
    .clk    (clk),
    .enable (tim_enable),
    .mid    (),
    .last   (tim_last)
  );

  always_comb begin
    state_next = state;
    shift_next = shift;
    case (state)
      IDLE: begin
        if (wr) begin
          state_next = START;
          shift_next = tx_data;
        end
      end
      START: if (tim_last) state_next = DATA;
      DATA: begin
        if (tim_last) begin
          shift_next = {1'b0, shift[DATA_BITS-1:1]};
          if (bits_done) begin
            state_next = STOP;
          end
        end
      end
      STOP: if (tim_last) state_next = IDLE;
      default: state_next = IDLE;
    endcase
    // line level follows the next state so tx lines up with it
    case (state_next)
      START:   tx_next = 1'b0;
      DATA:    tx_next = shift_next[0];
      default: tx_next = 1'b1; // idle and stop
    endcase
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state   <= IDLE;
      tx      <= 1'b1;
      bit_cnt <= '0;
    end else begin
      state <= state_next;
      tx    <= tx_next;
      if (state != DATA) begin
        bit_cnt <= '0;
      end else if (tim_last) begin
        bit_cnt <= bits_done ? '0 : bit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge rst) begin
    shift <= shift_next;
  end

  a_wr_when_idle: assert property (
    @(posedge rst) disable iff (clk)
    wr |-> (state == IDLE)
  );

  a_tx_high_idle: assert property (
    @(posedge rst) disable iff (clk)
    (state == IDLE) |-> tx
  );

  // start, data and stop span exactly one frame time
  a_frame_length: assert property (
    @(posedge rst) disable iff (clk)
    wr |=> (state != IDLE) [*((DATA_BITS + 2) * BIT_PERIOD)] ##1 (state == IDLE)
  );

endmodule

// ==== hdl/uart_rx.sv ====
module uart_rx
  import uart_pkg::*;
(
  input  logic       rst,
  input  logic       clk,
  input  logic       line_clean,
  input  logic       rd,
  output uart_data_t rx_data,
  output logic       rx_full
);

  line_state_t              state;
  line_state_t              state_next;
  logic [BIT_CNT_WIDTH-1:0] bit_cnt;
  uart_data_t               shift;
  logic                     tim_enable;
  logic                     tim_mid;
  logic                     tim_last;
  logic                     bits_done;
  logic                     load;

  assign tim_enable = (state != IDLE);
  assign bits_done  = (bit_cnt == BIT_CNT_WIDTH'(DATA_BITS - 1));
  assign load       = (state == STOP) && tim_last; // end of stop bit

  bit_timer u_bit_timer (
    .rst    (rst),
    .clk    (clk),
    .enable (tim_enable),
    .mid    (tim_mid),
    .last   (tim_last)
  );

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (!line_clean) begin
          state_next = START; // start edge
        end
      end
      START: begin
        if (tim_last) begin
          state_next = DATA;
        end
      end
      DATA: begin
        if (tim_last && bits_done) begin
          state_next = STOP;
        end
      end
      STOP: begin
        if (tim_last) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      bit_cnt <= '0;
    end else if (state != DATA) begin
      bit_cnt <= '0;
    end else if (tim_last) begin
      bit_cnt <= bits_done ? '0 : bit_cnt + 1'b1;
    end
  end

  // sample at bit center, lsb arrives first
  always_ff @(posedge rst) begin
    if ((state == DATA) && tim_mid) begin
      shift <= {line_clean, shift[DATA_BITS-1:1]};
    end
  end

  // one-entry buffer, a fresh byte wins over rd
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rx_data <= '0;
      rx_full <= 1'b0;
    end else if (load) begin
      rx_data <= shift;
      rx_full <= 1'b1;
    end else if (rd) begin
      rx_full <= 1'b0;
    end
  end

  a_bit_cnt_range: assert property (
    @(posedge rst) disable iff (clk)
    bit_cnt < BIT_CNT_WIDTH'(DATA_BITS)
  );

endmodule

// ==== hdl/rx_line_filter.sv ====
module rx_line_filter
  import uart_pkg::*;
(
  input  logic rst,
  input  logic clk,
  input  logic rx,
  output logic line_clean
);

  logic [FILTER_LEN-1:0] samples;
  logic                  all_high;
  logic                  all_low;

  assign all_high = &samples;
  assign all_low  = ~|samples;

  // sample chain, first stages also act as the synchronizer
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      samples <= '1; // idle line
    end else begin
      samples <= {samples[FILTER_LEN-2:0], rx};
    end
  end

  // hysteresis, only a unanimous window moves the output
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      line_clean <= 1'b1;
    end else if (all_high) begin
      line_clean <= 1'b1;
    end else if (all_low) begin
      line_clean <= 1'b0;
    end
  end

  // a falling clean line needs a full window of low raw samples behind it
  a_fall_needs_run: assert property (
    @(posedge rst) disable iff (clk)
    $fell(line_clean) |-> ($past(rx, 2) == 1'b0) && ($past(rx, FILTER_LEN + 1) == 1'b0)
  );

endmodule

// ==== hdl/bit_timer.sv ====
module bit_timer
  import uart_pkg::*;
(
  input  logic rst,
  input  logic clk,
  input  logic enable,
  output logic mid,
  output logic last
);

  logic [TIM_WIDTH-1:0] count;
  logic                 wrap;

  assign wrap = (count == TIM_WIDTH'(BIT_PERIOD - 1));
  assign mid  = enable && (count == TIM_WIDTH'(BIT_PERIOD / 2)); // bit center
  assign last = enable && wrap;                                  // final cycle of bit

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      count <= '0;
    end else if (!enable) begin
      count <= '0; // parked while idle
    end else if (wrap) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  a_count_range: assert property (
    @(posedge rst) disable iff (clk)
    count < TIM_WIDTH'(BIT_PERIOD)
  );

endmodule

// ==== hdl/uart_pkg.sv ====
package uart_pkg;

  // line timing
  localparam int CLOCK_HZ   = 1_000_000;
  localparam int BAUD       = 62_500;
  localparam int BIT_PERIOD = CLOCK_HZ / BAUD; // clocks per bit

  // widths and depths
  localparam int TIM_WIDTH     = 16;
  localparam int DATA_BITS     = 8;
  localparam int FILTER_LEN    = 4;            // rx glitch filter samples
  localparam int BIT_CNT_WIDTH = $clog2(DATA_BITS + 1);

  // one character on the wire
  typedef logic [DATA_BITS-1:0] uart_data_t;

  // frame position, shared by both directions
  typedef enum logic [1:0] {
    IDLE,  // line high, waiting
    START, // start bit
    DATA,  // data bits, lsb first
    STOP   // stop bit
  } line_state_t;

endpackage
